//--- build.f
design/axi_b_pkg.sv
design/write_done_tracker.sv
design/bresp_arbiter.sv
design/bresp_decoder.sv
design/bresp_xbar.sv
verification/clk_gen.sv
verification/tb_bresp_xbar.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_bresp_xbar \
  && ./obj_dir/Vtb_bresp_xbar | tee /dev/stderr | grep -x "Done: no errors" > /dev/null \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }

//--- verification/tb_bresp_xbar.sv
`timescale 1ns/1ps

module tb_bresp_xbar;

  import axi_b_pkg::*;

  localparam int TIMEOUT = 200;  // Cycles per wait loop

  logic                   clk;
  logic                   rstn;
  bs_beat_t               s_beat [NUM_SLAVES];
  logic [NUM_SLAVES-1:0]  s_bvalid;
  logic [NUM_SLAVES-1:0]  s_bready;
  w_strobe_t              m_w [NUM_MASTERS];
  bm_beat_t               m_beat [NUM_MASTERS];
  logic [NUM_MASTERS-1:0] m_bvalid;
  logic [NUM_MASTERS-1:0] m_bready;
  logic                   decerr;

  // Slave models with one outstanding response each
  bs_beat_t              slv_beat [NUM_SLAVES];
  logic [NUM_SLAVES-1:0] slv_busy;
  int                    exp_order [$];
  logic [31:0]           rng = 32'hdfd3_191c;
  int                    mismatches = 0;
  int                    timeouts = 0;
  int                    other_errs = 0;

  clk_gen u_clk_gen (
    .clk  (clk),
    .rstn (rstn)
  );

  bresp_xbar DUT (
    .clk      (clk),
    .rstn     (rstn),
    .s_beat   (s_beat),
    .s_bvalid (s_bvalid),
    .s_bready (s_bready),
    .m_w      (m_w),
    .m_beat   (m_beat),
    .m_bvalid (m_bvalid),
    .m_bready (m_bready),
    .decerr   (decerr)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_next();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
      mismatches++;
    end
  endtask

  task automatic drive_slaves();
    for (int s = 0; s < NUM_SLAVES; s++) begin
      s_beat[s] = slv_beat[s];
    end
    s_bvalid = slv_busy;
  endtask

  task automatic load_slave(input int s, input logic [MST_BITS-1:0] field);
    logic [31:0] r;
    r = rand_next();
    slv_beat[s].id   = {field, r[ID_BITS-1:0]};
    slv_beat[s].resp = r[5:4];
    slv_busy[s]      = 1'b1;
  endtask

  // n accepted WLAST beats in a row with the B side idle
  task automatic send_wlast(input int m, input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      m_bready = '0;
      m_w[m]   = '{wvalid: 1'b1, wready: 1'b1, wlast: 1'b1};
    end
    @(negedge clk);
    m_w[m] = '0;
  endtask

  // Walk the lock rule over the valid slaves from the slot after last
  task automatic predict_order(input logic [NUM_SLAVES-1:0] mask, input int last);
    logic [NUM_SLAVES-1:0] left;
    int                    cur;
    int                    idx;
    bit                    found;
    left = mask;
    cur  = last;
    exp_order.delete();
    while (left != '0) begin
      found = 1'b0;
      for (int k = 1; k <= NUM_SLAVES; k++) begin
        idx = (cur + k) % NUM_SLAVES;
        if (!found && left[idx]) begin
          cur   = idx;
          found = 1'b1;
        end
      end
      exp_order.push_back(cur);
      left[cur] = 1'b0;
    end
  endtask

  task automatic take_delivery(input int m, output int s_taken);
    int s;
    s_taken = -1;
    if (exp_order.size() == 0) begin
      $display("Unexpected response delivered to master %0d at time %0t", m, $time);
      other_errs++;
    end else begin
      s = exp_order.pop_front();
      check_val("routed master", 32'(slv_beat[s].id[IDS_BITS-1 -: MST_BITS]), m);
      check_val($sformatf("m_beat[%0d].id", m), 32'(slv_beat[s].id[ID_BITS-1:0]),
                32'(m_beat[m].id));
      check_val($sformatf("m_beat[%0d].resp", m), 32'(slv_beat[s].resp), 32'(m_beat[m].resp));
      slv_busy[s] = 1'b0;
      s_taken     = s;
    end
  endtask

  // Runs the slave and master models until every loaded response is taken
  task automatic serve(input bit stall);
    bm_beat_t               prev_beat [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] prev_stall;
    logic [NUM_SLAVES-1:0]  acc;
    int                     cyc;
    int                     s_taken;
    prev_stall = '0;
    cyc        = 0;
    while (slv_busy != '0 && cyc < TIMEOUT) begin
      @(negedge clk);
      drive_slaves();
      m_bready = stall ? NUM_MASTERS'(rand_next()) : '1;
      #10;
      acc = '0;
      check_val("decerr", 0, 32'(decerr));
      for (int i = 0; i < NUM_MASTERS; i++) begin
        if (prev_stall[i]) begin
          check_val($sformatf("m_bvalid[%0d] held", i), 1, 32'(m_bvalid[i]));
          check_val($sformatf("m_beat[%0d] held", i), 32'(prev_beat[i]), 32'(m_beat[i]));
        end
        prev_stall[i] = m_bvalid[i] & ~m_bready[i];
        prev_beat[i]  = m_beat[i];
        if (m_bvalid[i] && m_bready[i]) begin
          take_delivery(i, s_taken);
          if (s_taken >= 0) acc[s_taken] = 1'b1;
        end
      end
      check_val("s_bvalid & s_bready", 32'(acc), 32'(s_bvalid & s_bready));
      cyc++;
    end
    @(negedge clk);
    drive_slaves();
    m_bready = '0;
    if (slv_busy != '0) begin
      $display("Timeout: responses from slaves %b never delivered", slv_busy);
      timeouts++;
    end
  endtask

  // Response must sit unseen while its master has no finished burst
  task automatic hold_check(input int s, input int m, input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      drive_slaves();
      m_bready = '1;
      #10;
      check_val($sformatf("m_bvalid[%0d] gated", m), 0, 32'(m_bvalid[m]));
      check_val($sformatf("s_bready[%0d] gated", s), 0, 32'(s_bready[s]));
    end
  endtask

  task automatic wait_reset();
    int cyc;
    cyc = 0;
    while (rstn !== 1'b1 && cyc < TIMEOUT) begin
      @(posedge clk);
      cyc++;
    end
    if (rstn !== 1'b1) begin
      $display("Timeout: reset was never released");
      timeouts++;
    end
  endtask

  // Any locked slave would see ready for a beat aimed at master 3
  task automatic test_reset();
    @(negedge clk);
    for (int s = 0; s < NUM_SLAVES; s++) begin
      s_beat[s].id = {MST_BITS'(3), ID_BITS'(0)};
    end
    m_bready = '1;
    #10;
    check_val("m_bvalid", 0, 32'(m_bvalid));
    check_val("s_bready", 0, 32'(s_bready));
    check_val("decerr", 0, 32'(decerr));
    @(negedge clk);
    drive_slaves();
    m_bready = '0;
  endtask

  task automatic test_single_routing();
    int s;
    for (int k = 0; k < NUM_MASTERS; k++) begin
      for (int j = 0; j < 3; j++) begin
        s = (k + 2 * j) % NUM_SLAVES;
        load_slave(s, MST_BITS'(k));
        send_wlast(k, 1);
        predict_order(NUM_SLAVES'(1) << s, NUM_SLAVES - 1);
        serve(1'b0);
      end
    end
  endtask

  task automatic test_gating();
    load_slave(3, 2'd2);
    hold_check(3, 2, 8);
    send_wlast(2, 1);
    predict_order(NUM_SLAVES'(1) << 3, NUM_SLAVES - 1);
    serve(1'b0);
    load_slave(5, 2'd2);  // No second WLAST yet
    hold_check(5, 2, 8);
    send_wlast(2, 1);
    predict_order(NUM_SLAVES'(1) << 5, NUM_SLAVES - 1);
    serve(1'b0);
  endtask

  task automatic test_round_robin(input bit stall, input int rounds);
    logic [NUM_SLAVES-1:0] mask;
    logic [MST_BITS-1:0]   field;
    int                    cnt [NUM_MASTERS];
    int                    pivot;
    for (int r = 0; r < rounds; r++) begin
      mask  = NUM_SLAVES'(rand_next()) | NUM_SLAVES'(17);
      pivot = 1 + int'(rand_next() % 4);  // Slave 4 always at or above it
      cnt   = '{0, 0, 0};
      for (int s = 0; s < NUM_SLAVES; s++) begin
        if (mask[s]) begin
          field = MST_BITS'(rand_next() % 3);
          load_slave(s, field);
          cnt[field]++;
        end
      end
      // Upper slaves take the lock before the lower ones arrive
      @(negedge clk);
      drive_slaves();
      s_bvalid = mask & ({NUM_SLAVES{1'b1}} << pivot);
      m_bready = '0;
      for (int m = 0; m < NUM_MASTERS; m++) begin
        if (cnt[m] > 0) send_wlast(m, cnt[m]);
      end
      predict_order(mask, pivot - 1);
      serve(stall);
    end
  endtask

  task automatic test_decerr();
    int pulses;
    int cyc;
    pulses = 0;
    cyc    = 0;
    load_slave(1, 2'd3);
    while (slv_busy[1] && cyc < TIMEOUT) begin
      @(negedge clk);
      drive_slaves();
      m_bready = '1;
      #10;
      check_val("m_bvalid", 0, 32'(m_bvalid));
      if (decerr) pulses++;
      if (s_bvalid[1] && s_bready[1]) slv_busy[1] = 1'b0;
      cyc++;
    end
    if (slv_busy[1]) begin
      $display("Timeout: response for master 3 was never consumed");
      timeouts++;
    end
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      drive_slaves();
      #10;
      check_val("m_bvalid", 0, 32'(m_bvalid));
      if (decerr) pulses++;
    end
    m_bready = '0;
    check_val("decerr pulses", 1, pulses);
  endtask

  initial begin
    s_bvalid = '0;
    m_bready = '0;
    slv_busy = '0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      s_beat[s]   = '0;
      slv_beat[s] = '0;
    end
    for (int m = 0; m < NUM_MASTERS; m++) begin
      m_w[m] = '0;
    end
    wait_reset();
    test_reset();
    test_single_routing();
    test_gating();
    test_round_robin(1'b0, 4);
    test_round_robin(1'b1, 6);  // Random bready stalls
    test_decerr();
    $display("Errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts, other_errs);
    if (mismatches + timeouts + other_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic rstn
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Released on a falling edge, clear of the DUT's sampling edge
  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

//--- design/bresp_xbar.sv
`timescale 1ns/1ps

module bresp_xbar (
  input  logic                               clk,
  input  logic                               rstn,
  // Slave side
  input  axi_b_pkg::bs_beat_t                s_beat [axi_b_pkg::NUM_SLAVES],
  input  logic [axi_b_pkg::NUM_SLAVES-1:0]   s_bvalid,
  output logic [axi_b_pkg::NUM_SLAVES-1:0]   s_bready,
  // Master side
  input  axi_b_pkg::w_strobe_t               m_w [axi_b_pkg::NUM_MASTERS],
  output axi_b_pkg::bm_beat_t                m_beat [axi_b_pkg::NUM_MASTERS],
  output logic [axi_b_pkg::NUM_MASTERS-1:0]  m_bvalid,
  input  logic [axi_b_pkg::NUM_MASTERS-1:0]  m_bready,
  output logic                               decerr
);

  import axi_b_pkg::*;

  logic [NUM_MASTERS-1:0] pending;
  logic [NUM_MASTERS-1:0] b_done;
  bs_beat_t               sel_beat;
  logic                   sel_valid;
  logic                   sel_ready;

  // Completed bursts still owed a response
  write_done_tracker u_tracker (
    .clk     (clk),
    .rstn    (rstn),
    .m_w     (m_w),
    .b_done  (b_done),
    .pending (pending)
  );

  bresp_arbiter u_arbiter (
    .clk       (clk),
    .rstn      (rstn),
    .s_beat    (s_beat),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .sel_beat  (sel_beat),
    .sel_valid (sel_valid),
    .sel_ready (sel_ready)
  );

  // Routing and WLAST gating
  bresp_decoder u_decoder (
    .clk       (clk),
    .rstn      (rstn),
    .sel_beat  (sel_beat),
    .sel_valid (sel_valid),
    .sel_ready (sel_ready),
    .pending   (pending),
    .m_beat    (m_beat),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready),
    .b_done    (b_done),
    .decerr    (decerr)
  );

endmodule

//--- design/bresp_decoder.sv
`timescale 1ns/1ps

module bresp_decoder (
  input  logic                               clk,
  input  logic                               rstn,
  input  axi_b_pkg::bs_beat_t                sel_beat,
  input  logic                               sel_valid,
  output logic                               sel_ready,
  input  logic [axi_b_pkg::NUM_MASTERS-1:0]  pending,
  output axi_b_pkg::bm_beat_t                m_beat [axi_b_pkg::NUM_MASTERS],
  output logic [axi_b_pkg::NUM_MASTERS-1:0]  m_bvalid,
  input  logic [axi_b_pkg::NUM_MASTERS-1:0]  m_bready,
  output logic [axi_b_pkg::NUM_MASTERS-1:0]  b_done,
  output logic                               decerr
);

  import axi_b_pkg::*;

  b_master_e mst;
  bm_beat_t  stripped;

  assign mst = decode_master(sel_beat.id);

  // Drop the master field, keep the master-side ID
  assign stripped.id   = sel_beat.id[ID_BITS-1:0];
  assign stripped.resp = sel_beat.resp;

  always_comb begin
    for (int m = 0; m < NUM_MASTERS; m++) begin
      m_beat[m].id   = '0;
      m_beat[m].resp = RESP_SLVERR;
    end
    m_bvalid  = '0;
    b_done    = '0;
    sel_ready = 1'b0;
    decerr    = 1'b0;

    unique case (mst)
      MST_M0, MST_M1, MST_M2: begin
        m_beat[mst] = stripped;
        // Held back until this master has a finished burst
        if (pending[mst]) begin
          m_bvalid[mst] = sel_valid;
          sel_ready     = m_bready[mst];
          b_done[mst]   = sel_valid & m_bready[mst];
        end
      end
      MST_BAD: begin
        sel_ready = 1'b1;  // Swallow it
        decerr    = sel_valid;
      end
    endcase
  end

  a_one_master: assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot0(m_bvalid)
  ) else $error("BVALID raised to more than one master: %b", m_bvalid);

endmodule

//--- design/bresp_arbiter.sv
`timescale 1ns/1ps

module bresp_arbiter (
  input  logic                              clk,
  input  logic                              rstn,
  input  axi_b_pkg::bs_beat_t               s_beat [axi_b_pkg::NUM_SLAVES],
  input  logic [axi_b_pkg::NUM_SLAVES-1:0]  s_bvalid,
  output logic [axi_b_pkg::NUM_SLAVES-1:0]  s_bready,
  output axi_b_pkg::bs_beat_t               sel_beat,
  output logic                              sel_valid,
  input  logic                              sel_ready
);

  import axi_b_pkg::*;

  b_lock_e                 lock_q;
  b_lock_e                 lock_d;
  logic [SLV_IDX_BITS-1:0] cur_idx;
  logic                    accept;

  assign accept = sel_valid & sel_ready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_q <= LOCK_NO;
    end else begin
      lock_q <= lock_d;
    end
  end

  // Index of the locked slave, unused while idle
  always_comb begin
    cur_idx = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (lock_q[i]) begin
        cur_idx = SLV_IDX_BITS'(i);
      end
    end
  end

  always_comb begin
    lock_d = lock_q;
    if (lock_q[LOCK_NO_BIT]) begin
      // Lowest-numbered valid slave wins from idle
      for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
        if (s_bvalid[i]) begin
          lock_d = b_lock_e'(LOCK_BITS'(1) << i);
        end
      end
    end else if (accept) begin
      lock_d = LOCK_NO;
      // Scan from the far end so the nearest successor is written last
      for (int k = NUM_SLAVES - 1; k >= 1; k--) begin
        if (s_bvalid[(int'(cur_idx) + k) % NUM_SLAVES]) begin
          lock_d = b_lock_e'(LOCK_BITS'(1) << ((int'(cur_idx) + k) % NUM_SLAVES));
        end
      end
    end
  end

  // Forward the locked slave, ready goes back to it alone
  always_comb begin
    sel_beat.id   = '0;
    sel_beat.resp = RESP_SLVERR;
    sel_valid     = 1'b0;
    s_bready      = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (lock_q[i]) begin
        sel_beat    = s_beat[i];
        sel_valid   = s_bvalid[i];
        s_bready[i] = sel_ready;
      end
    end
  end

  a_lock_onehot: assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot(lock_q)
  ) else $error("B lock is not one-hot: %b", lock_q);

  // Lock is held until the decoder takes the beat
  a_lock_hold: assert property (
    @(posedge clk) disable iff (!rstn)
    !lock_q[LOCK_NO_BIT] && !accept |=> $stable(lock_q)
  ) else $error("B lock moved before the response was accepted");

  // Slave keeps its response up while it is locked and waiting
  a_locked_valid: assert property (
    @(posedge clk) disable iff (!rstn)
    !lock_q[LOCK_NO_BIT] && !accept |=> sel_valid
  ) else $error("Locked slave dropped BVALID before acceptance");

endmodule

//--- design/write_done_tracker.sv
`timescale 1ns/1ps

module write_done_tracker (
  input  logic                                clk,
  input  logic                                rstn,
  input  axi_b_pkg::w_strobe_t                m_w [axi_b_pkg::NUM_MASTERS],
  input  logic [axi_b_pkg::NUM_MASTERS-1:0]   b_done,
  output logic [axi_b_pkg::NUM_MASTERS-1:0]   pending
);

  import axi_b_pkg::*;

  logic [PEND_BITS-1:0]   cnt [NUM_MASTERS];
  logic [NUM_MASTERS-1:0] w_done;

  for (genvar g = 0; g < NUM_MASTERS; g++) begin : g_mst

    // Burst complete on the accepted WLAST beat
    assign w_done[g] = m_w[g].wvalid & m_w[g].wready & m_w[g].wlast;

    always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
        cnt[g] <= '0;
      end else begin
        case ({w_done[g], b_done[g]})
          2'b10:   cnt[g] <= cnt[g] + 1'b1;
          2'b01:   cnt[g] <= cnt[g] - 1'b1;
          default: cnt[g] <= cnt[g];  // Idle, or both events cancel
        endcase
      end
    end

    assign pending[g] = |cnt[g];

    // Decoder only completes a response while this master is pending
    a_no_underflow: assert property (
      @(posedge clk) disable iff (!rstn)
      b_done[g] && !w_done[g] |-> cnt[g] != '0
    ) else $error("pending count underflow on master %0d", g);

    // More outstanding bursts than the counter holds
    a_no_overflow: assert property (
      @(posedge clk) disable iff (!rstn)
      w_done[g] && !b_done[g] |-> cnt[g] != '1
    ) else $error("pending count overflow on master %0d", g);

  end

endmodule

//--- design/axi_b_pkg.sv
package axi_b_pkg;

  // Port counts
  localparam int NUM_MASTERS = 3;
  localparam int NUM_SLAVES  = 7;

  // ID widths, master field sits on top of the slave-side ID
  localparam int ID_BITS  = 4;
  localparam int MST_BITS = 2;
  localparam int IDS_BITS = ID_BITS + MST_BITS;

  localparam int RESP_BITS = 2;
  localparam logic [RESP_BITS-1:0] RESP_SLVERR = 2'b10;

  // Up to 7 completed bursts may wait per master
  localparam int PEND_BITS = 3;

  // One-hot lock, one bit per slave plus idle
  localparam int LOCK_BITS    = NUM_SLAVES + 1;
  localparam int LOCK_NO_BIT  = NUM_SLAVES;
  localparam int SLV_IDX_BITS = $clog2(NUM_SLAVES);

  typedef enum logic [LOCK_BITS-1:0] {
    LOCK_S0 = 8'b0000_0001,
    LOCK_S1 = 8'b0000_0010,
    LOCK_S2 = 8'b0000_0100,
    LOCK_S3 = 8'b0000_1000,
    LOCK_S4 = 8'b0001_0000,
    LOCK_S5 = 8'b0010_0000,
    LOCK_S6 = 8'b0100_0000,
    LOCK_NO = 8'b1000_0000
  } b_lock_e;

  typedef enum logic [MST_BITS-1:0] {
    MST_M0  = 2'd0,
    MST_M1  = 2'd1,
    MST_M2  = 2'd2,
    MST_BAD = 2'd3
  } b_master_e;

  typedef struct packed {
    logic [IDS_BITS-1:0]  id;
    logic [RESP_BITS-1:0] resp;
  } bs_beat_t;

  typedef struct packed {
    logic [ID_BITS-1:0]   id;
    logic [RESP_BITS-1:0] resp;
  } bm_beat_t;

  typedef struct packed {
    logic wvalid;
    logic wready;
    logic wlast;
  } w_strobe_t;

  // Master number from the top bits of the extended ID
  function automatic b_master_e decode_master(input logic [IDS_BITS-1:0] id);
    logic [MST_BITS-1:0] field;
    field = id[IDS_BITS-1 -: MST_BITS];
    case (field)
      2'd0:    return MST_M0;
      2'd1:    return MST_M1;
      2'd2:    return MST_M2;
      default: return MST_BAD;  // No master 3
    endcase
  endfunction

endpackage
